//--- include/sent_defines.svh
// line timing and CRC constants for the SENT transmitter; include wherever a value is needed
`ifndef SENT_DEFINES_SVH
`define SENT_DEFINES_SVH

// ----------------------------------------------------------------------
// clocking
// ----------------------------------------------------------------------
`define SENT_CLK_FREQ 10000000                        // system clock in Hz
`define SENT_CLKS_PER_US (`SENT_CLK_FREQ / 1000000)  // prescaler period

// ----------------------------------------------------------------------
// buffering
// ----------------------------------------------------------------------
`define SENT_FIFO_DEPTH 32 // queued frames, power of two

// ----------------------------------------------------------------------
// pulse lengths in ticks
// ----------------------------------------------------------------------
`define SENT_SYNC_TICKS 56        // calibration / sync pulse
`define SENT_NIBBLE_BASE_TICKS 12 // nibble of value 0

// recommended CRC-4, x^4+x^3+x^2+1 with the x^4 term implied
`define SENT_CRC_SEED 4'b0101
`define SENT_CRC_POLY 4'b1101

// line config after reset
`define SENT_DFLT_CTICK 8'd3       // 3 us tick
`define SENT_DFLT_LTICK 8'd4       // 4 low ticks
`define SENT_DFLT_PAUSE_LEN 10'd12 // shortest legal pause

`endif

//--- hdl/sent_pkg.sv
// shared SENT transmitter types, referenced by scoped name from each RTL block
`default_nettype none

package sent_pkg;

  // ----------------------------------------------------------------------
  // line configuration, 27 bits
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [7:0] ctick_len; // tick length in us, 3..90
    logic [7:0] ltick_len; // low phase ticks, >= 4
    logic       pause_en;  // append pause pulse after crc
    logic [9:0] pause_len; // pause in ticks, 12..768
  } sent_cfg_t;

  // ----------------------------------------------------------------------
  // one queued frame, 31 bits
  // ----------------------------------------------------------------------
  // data nibble 1 sits in data[23:20], nibble 6 in data[3:0]
  typedef struct packed {
    logic [2:0]  len;    // data nibbles, 1..6
    logic [3:0]  status; // status / comm nibble
    logic [23:0] data;   // up to six data nibbles
  } sent_frame_t;

  // ----------------------------------------------------------------------
  // frame engine states
  // ----------------------------------------------------------------------
  // one state per pulse kind on the line
  typedef enum logic [2:0] {
    IDLE   = 3'd0, // line high, waiting for a frame
    SYNC   = 3'd1, // 56 tick calibration pulse
    STATUS = 3'd2, // status nibble
    DATA   = 3'd3, // data nibbles
    CRC    = 3'd4, // checksum nibble
    PAUSE  = 3'd5  // optional pause pulse
  } sent_state_e;

endpackage

`default_nettype wire

//--- hdl/sent_host_if.sv
// host side of the SENT transmitter: frame write strobe and deferred config update
`timescale 1ns/1ns
`default_nettype none

`include "sent_defines.svh"

module sent_host_if (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfg_vld,     // one cycle config strobe
  input  sent_pkg::sent_cfg_t cfg,         // new config from host
  input  logic                frame_vld,   // frame strobe
  input  logic                engine_idle, // engine between frames
  input  logic                fifo_empty,  // registered fifo level
  output logic                wr,          // fifo write
  output sent_pkg::sent_cfg_t active_cfg   // config used on the line
);

  // ----------------------------------------------------------------------
  // pending config
  // ----------------------------------------------------------------------
  sent_pkg::sent_cfg_t cfg_pend; // last config written by host
  logic                pend;     // cfg_pend not applied yet
  logic                apply;    // safe point to switch config

  // only switch with nothing on the line and nothing queued
  assign apply = pend && engine_idle && fifo_empty;

  always_ff @(posedge clk)
  begin
    if (cfg_vld)
      cfg_pend <= cfg; // newest write wins
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pend <= 1'b0;
    else if (cfg_vld)
      pend <= 1'b1; // a write in the apply cycle stays pending
    else if (apply)
      pend <= 1'b0;
  end

  // ----------------------------------------------------------------------
  // active config
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active_cfg.ctick_len <= `SENT_DFLT_CTICK;
      active_cfg.ltick_len <= `SENT_DFLT_LTICK;
      active_cfg.pause_en  <= 1'b0;
      active_cfg.pause_len <= `SENT_DFLT_PAUSE_LEN;
    end
    else if (apply)
      active_cfg <= cfg_pend;
  end

  // frames go straight to the fifo, full drops happen there
  assign wr = frame_vld;

endmodule

`default_nettype wire

//--- hdl/sent_frame_fifo.sv
// frame buffer between host interface and frame engine; head shows the oldest frame at once
`timescale 1ns/1ns
`default_nettype none

`include "sent_defines.svh"

module sent_frame_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr,    // write strobe, ignored when full
  input  sent_pkg::sent_frame_t wdata, // frame to queue
  input  logic                  pop,   // drop head
  output sent_pkg::sent_frame_t head,  // oldest frame, no read latency
  output logic                  empty, // registered
  output logic                  full   // registered
);

  localparam int DEPTH = `SENT_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // ----------------------------------------------------------------------
  // storage and pointers
  // ----------------------------------------------------------------------
  sent_pkg::sent_frame_t mem [0:DEPTH-1];

  logic [AW:0] wr_ptr; // extra msb tells full from empty
  logic [AW:0] rd_ptr;
  logic        empty_now; // current pointer state
  logic        full_now;
  logic        wr_ok;
  logic        rd_ok;

  assign empty_now = (wr_ptr == rd_ptr);
  assign full_now  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // guards use the live state so nothing is overwritten in the flag lag cycle
  assign wr_ok = wr && !full_now;
  assign rd_ok = pop && !empty_now;

  always_ff @(posedge clk)
  begin
    if (wr_ok)
      mem[wr_ptr[AW-1:0]] <= wdata;
  end

  assign head = mem[rd_ptr[AW-1:0]]; // first word fall through

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // status flags, one cycle behind the pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      empty <= 1'b1;
      full  <= 1'b0;
    end
    else
    begin
      empty <= empty_now;
      full  <= full_now;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sent_tick_gen.sv
// SENT clock tick strobe from the system clock; ticks run only while a frame is on the line
`timescale 1ns/1ns
`default_nettype none

`include "sent_defines.svh"

module sent_tick_gen (
  input  logic       clk,
  input  logic       rst,
  input  logic       run,       // low holds the tick divider cleared
  input  logic [7:0] ctick_len, // tick length in us
  output logic       tick       // one cycle per SENT tick
);

  localparam int CLKS_PER_US = `SENT_CLKS_PER_US;
  localparam int PW          = $clog2(CLKS_PER_US + 1);
  localparam logic [PW-1:0] US_LAST = PW'(CLKS_PER_US - 1);

  logic [PW-1:0] us_cnt;   // clocks within a microsecond
  logic          us_stb;   // last clock of a microsecond
  logic [7:0]    tick_cnt; // microseconds within a tick
  logic          tick_last;

  // ----------------------------------------------------------------------
  // microsecond prescaler, free running
  // ----------------------------------------------------------------------
  assign us_stb = (us_cnt == US_LAST);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      us_cnt <= '0;
    else if (us_stb)
      us_cnt <= '0;
    else
      us_cnt <= us_cnt + 1'b1;
  end

  // ----------------------------------------------------------------------
  // tick divider
  // ----------------------------------------------------------------------
  assign tick_last = (tick_cnt == ctick_len - 8'd1);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      tick_cnt <= 8'd0;
    else if (!run)
      tick_cnt <= 8'd0; // restart so the first tick is a whole one
    else if (us_stb)
      tick_cnt <= tick_last ? 8'd0 : tick_cnt + 8'd1;
  end

  assign tick = run && us_stb && tick_last;

endmodule

`default_nettype wire

//--- hdl/sent_frame_engine.sv
// SENT frame sequencer: pulls frames from the FIFO and drives sync, nibbles, CRC and pause
`timescale 1ns/1ns
`default_nettype none

`include "sent_defines.svh"

module sent_frame_engine (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  tick,  // SENT tick strobe
  input  sent_pkg::sent_cfg_t   cfg,   // active line config
  input  sent_pkg::sent_frame_t head,  // fifo head
  input  logic                  empty, // registered fifo empty
  output logic                  pop,   // head consumed this cycle
  output logic                  idle,  // no frame on the line
  output logic                  sent   // line, idles high
);

  // one CRC-4 step: multiply remainder by x^4, reduce, add the new nibble
  function automatic logic [3:0] crc4_step(input logic [3:0] crc_in, input logic [3:0] nib);
    logic [3:0] r;
    int         i;
    r = crc_in;
    for (i = 0; i < 4; i++)
    begin
      if (r[3])
        r = {r[2:0], 1'b0} ^ `SENT_CRC_POLY;
      else
        r = {r[2:0], 1'b0};
    end
    return r ^ nib;
  endfunction

  // pulse length of a nibble in ticks
  function automatic logic [9:0] nib_ticks(input logic [3:0] nib);
    return 10'(`SENT_NIBBLE_BASE_TICKS) + {6'd0, nib};
  endfunction

  // ----------------------------------------------------------------------
  // state and counters
  // ----------------------------------------------------------------------
  sent_pkg::sent_state_e state;

  logic [9:0]  tick_cnt;  // ticks into current pulse
  logic [9:0]  pulse_len; // ticks of current pulse
  logic [27:0] nib_sr;    // status then data, current nibble on top
  logic [2:0]  len_q;     // data nibbles in this frame
  logic [2:0]  nib_cnt;   // data nibble now on the line, 1 based
  logic [3:0]  crc;       // running checksum

  logic       pulse_end;   // last tick of a pulse
  logic       frame_done;  // last pulse of the frame ends
  logic       start_frame; // load head and begin sync
  logic [3:0] next_nib;    // nibble after the one on the line
  logic [3:0] crc_next;    // checksum with next_nib folded in
  logic [3:0] crc_final;   // checksum extended by a zero nibble

  assign pulse_end  = tick && (tick_cnt == pulse_len - 10'd1);
  assign frame_done = pulse_end &&
                      ((state == sent_pkg::CRC && !cfg.pause_en) ||
                       state == sent_pkg::PAUSE);

  // back to back frames skip idle entirely
  assign start_frame = !empty && (state == sent_pkg::IDLE || frame_done);
  assign pop         = start_frame;
  assign idle        = (state == sent_pkg::IDLE);

  assign next_nib  = nib_sr[23:20];
  assign crc_next  = crc4_step(crc, next_nib);
  assign crc_final = crc4_step(crc, 4'd0); // recommended zero extension

  // ----------------------------------------------------------------------
  // sequencer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= sent_pkg::IDLE;
      tick_cnt  <= 10'd0;
      pulse_len <= 10'(`SENT_SYNC_TICKS);
      len_q     <= 3'd0;
      nib_cnt   <= 3'd0;
      crc       <= `SENT_CRC_SEED;
    end
    else if (start_frame)
    begin
      state     <= sent_pkg::SYNC;
      tick_cnt  <= 10'd0;
      pulse_len <= 10'(`SENT_SYNC_TICKS);
      len_q     <= head.len;
      nib_cnt   <= 3'd0;
      crc       <= `SENT_CRC_SEED; // status nibble not covered
    end
    else if (pulse_end)
    begin
      tick_cnt <= 10'd0;
      case (state)
        sent_pkg::SYNC:
        begin
          state     <= sent_pkg::STATUS;
          pulse_len <= nib_ticks(nib_sr[27:24]); // status
        end
        sent_pkg::STATUS:
        begin
          state     <= sent_pkg::DATA;
          pulse_len <= nib_ticks(next_nib);
          crc       <= crc_next;
          nib_cnt   <= 3'd1;
        end
        sent_pkg::DATA:
        begin
          if (nib_cnt >= len_q)
          begin
            state     <= sent_pkg::CRC;
            pulse_len <= nib_ticks(crc_final);
            crc       <= crc_final;
          end
          else
          begin
            pulse_len <= nib_ticks(next_nib);
            crc       <= crc_next;
            nib_cnt   <= nib_cnt + 3'd1;
          end
        end
        sent_pkg::CRC:
        begin
          if (cfg.pause_en)
          begin
            state     <= sent_pkg::PAUSE;
            pulse_len <= cfg.pause_len;
          end
          else
            state <= sent_pkg::IDLE; // fifo empty, else start_frame won
        end
        default:
          state <= sent_pkg::IDLE; // end of pause
      endcase
    end
    else if (tick)
      tick_cnt <= tick_cnt + 10'd1;
  end

  // nibble shifter, top nibble is the one on the line
  always_ff @(posedge clk)
  begin
    if (start_frame)
      nib_sr <= {head.status, head.data};
    else if (pulse_end && (state == sent_pkg::STATUS || state == sent_pkg::DATA))
      nib_sr <= nib_sr << 4;
  end

  // ----------------------------------------------------------------------
  // line driver
  // ----------------------------------------------------------------------
  // low for the first ltick_len ticks of each pulse, one clock behind the tick
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      sent <= 1'b1;
    else
      sent <= !(state != sent_pkg::IDLE && tick_cnt < {2'd0, cfg.ltick_len});
  end

endmodule

`default_nettype wire

//--- hdl/sent_tx.sv
// SENT transmitter top: host interface, frame FIFO, tick generator and frame engine
`timescale 1ns/1ns
`default_nettype none

module sent_tx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cfg_vld,    // config strobe
  input  sent_pkg::sent_cfg_t   cfg,        // config word
  input  logic                  frame_vld,  // frame strobe
  input  sent_pkg::sent_frame_t frame,      // frame word
  output logic                  fifo_empty, // registered
  output logic                  fifo_full,  // registered, writes dropped
  output logic                  sent        // SENT line
);

  // ----------------------------------------------------------------------
  // interconnect
  // ----------------------------------------------------------------------
  logic                  wr;
  sent_pkg::sent_cfg_t   active_cfg;
  sent_pkg::sent_frame_t head;
  logic                  pop;
  logic                  idle;
  logic                  tick;

  sent_host_if u_host_if (
    .clk         (clk),
    .rst         (rst),
    .cfg_vld     (cfg_vld),
    .cfg         (cfg),
    .frame_vld   (frame_vld),
    .engine_idle (idle),
    .fifo_empty  (fifo_empty),
    .wr          (wr),
    .active_cfg  (active_cfg)
  );

  sent_frame_fifo u_fifo (
    .clk   (clk),
    .rst   (rst),
    .wr    (wr),
    .wdata (frame),
    .pop   (pop),
    .head  (head),
    .empty (fifo_empty),
    .full  (fifo_full)
  );

  // divider only runs while a frame is in flight
  sent_tick_gen u_tick_gen (
    .clk       (clk),
    .rst       (rst),
    .run       (!idle),
    .ctick_len (active_cfg.ctick_len),
    .tick      (tick)
  );

  sent_frame_engine u_engine (
    .clk   (clk),
    .rst   (rst),
    .tick  (tick),
    .cfg   (active_cfg),
    .head  (head),
    .empty (fifo_empty),
    .pop   (pop),
    .idle  (idle),
    .sent  (sent)
  );

endmodule

`default_nettype wire

//--- tests/sent_tx_assertions.sv
// protocol checks on pop, FIFO flags and idle line level that bind into the SENT transmitter top
`timescale 1ns/1ns
`default_nettype none

module sent_tx_assertions (
  input logic clk,
  input logic rst,
  input logic pop,   // engine takes the fifo head
  input logic empty, // live fifo empty from the pointers
  input logic full,  // registered fifo full
  input logic idle,  // engine between frames
  input logic sent   // SENT line
);

  int fail_cnt = 0; // failures so far

  // engine only takes a frame that is really there, flag lag or not
  pop_needs_data : assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
  else
  begin
    fail_cnt++;
    $error("pop while the fifo is empty");
  end

  // line rests high between frames
  idle_line_high : assert property (@(posedge clk) disable iff (rst) idle |-> sent)
  else
  begin
    fail_cnt++;
    $error("sent low while the engine is idle");
  end

  // full flag lags the pointers by one clock
  flags_exclusive : assert property (@(posedge clk) disable iff (rst) !(full && empty))
  else
  begin
    fail_cnt++;
    $error("fifo full and empty together");
  end

endmodule

`default_nettype wire

//--- tests/sent_tx_tb.sv
// directed testbench that runs the SENT transmitter through its frame and config tests as top
`timescale 1ns/1ns
`default_nettype none

`include "sent_defines.svh"

module sent_tx_tb;

  localparam int CLK_PERIOD    = 100; // 10 MHz
  localparam int BASE          = `SENT_NIBBLE_BASE_TICKS;
  localparam int FRAME_TICKS   = `SENT_SYNC_TICKS + 8 * (BASE + 15); // worst case frame
  // 35 frames at 3 us, one at 5 us and two paused ones at 5 us
  localparam int RUN_US        = FRAME_TICKS * 3 * 35 + FRAME_TICKS * 5 +
                                 (FRAME_TICKS + 100) * 5 * 2;
  localparam int WATCHDOG_CLKS = RUN_US * `SENT_CLKS_PER_US * 5 / 4 + 2000;

  // one decoded pulse from falling edge to falling edge
  typedef struct packed {
    logic [31:0] clks; // period in clocks
    logic [31:0] low;  // low phase in clocks
    logic        last; // engine idle after it
  } pulse_t;

  logic                  clk;
  logic                  rst;
  logic                  cfg_vld;
  sent_pkg::sent_cfg_t   cfg;
  logic                  frame_vld;
  sent_pkg::sent_frame_t frame;
  logic                  fifo_empty;
  logic                  fifo_full;
  logic                  sent;

  logic [31:0] lfsr   = 32'hb106_e6cc;
  int          checks = 0;
  int          errors = 0;
  pulse_t      pulses [$]; // decoder output with the oldest first

  sent_tx u_dut (
    .clk        (clk),
    .rst        (rst),
    .cfg_vld    (cfg_vld),
    .cfg        (cfg),
    .frame_vld  (frame_vld),
    .frame      (frame),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .sent       (sent)
  );

  bind sent_tx sent_tx_assertions u_assert (
    .clk   (clk),
    .rst   (rst),
    .pop   (pop),
    .empty (u_fifo.empty_now),
    .full  (fifo_full),
    .idle  (idle),
    .sent  (sent)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // line decoder sampled mid cycle
  // ----------------------------------------------------------------------
  logic        in_pulse = 1'b0;
  logic        sent_q   = 1'b1;
  logic        idle_q   = 1'b1;
  logic [31:0] pulse_cnt;
  logic [31:0] low_cnt;

  always @(negedge clk)
  begin
    if (in_pulse)
      pulse_cnt = pulse_cnt + 1;
    if (!rst && sent_q && !sent)
    begin
      if (in_pulse)
        pulses.push_back('{pulse_cnt, low_cnt, 1'b0});
      in_pulse  = 1'b1;
      pulse_cnt = 0;
      low_cnt   = 0;
    end
    if (in_pulse && !sent)
      low_cnt = low_cnt + 1;
    // no falling edge ends the last pulse so it closes where the next sync would fall
    if (in_pulse && u_dut.idle && !idle_q)
    begin
      pulses.push_back('{pulse_cnt + 1, low_cnt, 1'b1});
      in_pulse = 1'b0;
    end
    sent_q = sent;
    idle_q = u_dut.idle;
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  // fibonacci lfsr x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic sent_pkg::sent_frame_t random_frame();
    sent_pkg::sent_frame_t f;
    f.len    = 3'(take_bits(8) % 6 + 1);
    f.status = 4'(take_bits(4));
    f.data   = 24'(take_bits(24)); // unused nibbles carry junk
    return f;
  endfunction

  // divide seed, sent data nibbles and one zero nibble msb first and keep the remainder
  function automatic logic [3:0] crc_expect(input sent_pkg::sent_frame_t f);
    logic [27:0] msg;
    logic [3:0]  r;
    logic        b;
    logic        fb;
    int          i;
    msg = {`SENT_CRC_SEED, f.data};
    r   = 4'd0;
    for (i = 0; i < 4 * (f.len + 2); i++)
    begin
      b  = (i < 4 * (f.len + 1)) ? msg[27 - i] : 1'b0; // zero nibble last
      fb = r[3];
      r  = {r[2:0], b};
      if (fb)
        r = r ^ `SENT_CRC_POLY; // x^4 term drops out
    end
    return r;
  endfunction

  task automatic write_cfg(input sent_pkg::sent_cfg_t c);
    @(posedge clk);
    cfg_vld <= 1'b1;
    cfg     <= c;
    @(posedge clk);
    cfg_vld <= 1'b0;
  endtask

  task automatic write_frame(input sent_pkg::sent_frame_t f);
    @(posedge clk);
    frame_vld <= 1'b1; // stays up for back to back writes
    frame     <= f;
  endtask

  task automatic end_writes();
    @(posedge clk);
    frame_vld <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ticks(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_frame(input sent_pkg::sent_frame_t got, input sent_pkg::sent_frame_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t frame got %h expected %h", $time, got, exp);
    end
  endtask

  // next pulse rounded to whole ticks with its low phase checked on the way
  task automatic read_pulse(input sent_pkg::sent_cfg_t c, output int ticks, output logic last);
    pulse_t p;
    int     tclk;
    tclk = c.ctick_len * `SENT_CLKS_PER_US;
    while (pulses.size() == 0)
      @(posedge clk); // watchdog bounds this
    p     = pulses.pop_front();
    ticks = (p.clks + tclk / 2) / tclk;
    last  = p.last;
    check_ticks("sent low ticks", (p.low + tclk / 2) / tclk, c.ltick_len);
  endtask

  // decode one frame from the line and compare with what was queued
  task automatic expect_frame(input sent_pkg::sent_frame_t f, input sent_pkg::sent_cfg_t c,
                              input logic ends_burst);
    sent_pkg::sent_frame_t got;
    sent_pkg::sent_frame_t exp;
    int                    ticks;
    logic                  last;
    int                    i;
    exp     = f;
    got     = '0;
    got.len = f.len;
    read_pulse(c, ticks, last);
    check_ticks("sync ticks", ticks, `SENT_SYNC_TICKS);
    read_pulse(c, ticks, last);
    got.status = 4'(ticks - BASE);
    for (i = 0; i < 6; i++)
    begin
      if (i < f.len)
      begin
        read_pulse(c, ticks, last);
        got.data[23 - 4 * i -: 4] = 4'(ticks - BASE);
      end
      else
        exp.data[23 - 4 * i -: 4] = 4'd0; // never on the line
    end
    read_pulse(c, ticks, last);
    check_nibble("crc nibble", 4'(ticks - BASE), crc_expect(f));
    if (c.pause_en)
    begin
      read_pulse(c, ticks, last);
      check_ticks("pause ticks", ticks, c.pause_len);
    end
    check_level("engine idle after frame", last, ends_burst);
    check_frame(got, exp);
  endtask

  task automatic report(input string name, input int err0);
    if (errors == err0)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - err0);
  endtask

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic reset_levels();
    int err0;
    err0 = errors;
    @(negedge clk);
    check_level("sent", sent, 1'b1);
    check_level("fifo_empty", fifo_empty, 1'b1);
    check_level("fifo_full", fifo_full, 1'b0);
    report("reset levels", err0);
  endtask

  task automatic single_frame(input sent_pkg::sent_cfg_t c);
    sent_pkg::sent_frame_t f;
    int                    err0;
    err0 = errors;
    f    = random_frame();
    write_frame(f);
    end_writes();
    expect_frame(f, c, 1'b1);
    report("single random frame", err0);
  endtask

  task automatic deferred_config(input sent_pkg::sent_cfg_t old_c,
                                 input sent_pkg::sent_cfg_t new_c);
    sent_pkg::sent_frame_t f;
    int                    err0;
    err0 = errors;
    f    = random_frame();
    write_frame(f);
    end_writes();
    while (sent)
      @(negedge clk); // frame under way
    write_cfg(new_c);
    expect_frame(f, old_c, 1'b1); // old timing to the end
    f = random_frame();
    write_frame(f);
    end_writes();
    expect_frame(f, new_c, 1'b1);
    report("deferred config", err0);
  endtask

  task automatic paused_pair(input sent_pkg::sent_cfg_t c);
    sent_pkg::sent_frame_t fa;
    sent_pkg::sent_frame_t fb;
    int                    err0;
    err0 = errors;
    fa   = random_frame();
    fb   = random_frame();
    write_cfg(c); // idle and empty so it applies at once
    write_frame(fa);
    write_frame(fb);
    end_writes();
    expect_frame(fa, c, 1'b0); // pause ends at the next sync
    expect_frame(fb, c, 1'b1);
    report("pause pulse", err0);
  endtask

  task automatic fifo_overflow(input sent_pkg::sent_cfg_t c);
    sent_pkg::sent_frame_t q [$];
    logic                  seen;
    int                    err0;
    int                    i;
    err0 = errors;
    write_cfg(c);
    for (i = 0; i < `SENT_FIFO_DEPTH + 2; i++)
      q.push_back(random_frame());
    for (i = 0; i < `SENT_FIFO_DEPTH + 2; i++)
      write_frame(q[i]); // one frame leaves early and the last one is dropped
    end_writes();
    @(negedge clk);
    seen = fifo_full;
    @(negedge clk);
    seen = seen | fifo_full;
    check_level("fifo_full", seen, 1'b1);
    for (i = 0; i <= `SENT_FIFO_DEPTH; i++)
      expect_frame(q[i], c, i == `SENT_FIFO_DEPTH);
    @(negedge clk);
    check_level("fifo_empty", fifo_empty, 1'b1);
    report("fifo overflow", err0);
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial
  begin
    rst       = 1'b1;
    cfg_vld   = 1'b0;
    cfg       = '{8'd3, 8'd4, 1'b0, 10'd12};
    frame_vld = 1'b0;
    frame     = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    reset_levels();
    single_frame('{8'd3, 8'd4, 1'b0, 10'd12}); // reset config
    deferred_config('{8'd3, 8'd4, 1'b0, 10'd12}, '{8'd5, 8'd6, 1'b0, 10'd12});
    paused_pair('{8'd5, 8'd6, 1'b1, 10'd100});
    fifo_overflow('{8'd3, 8'd4, 1'b0, 10'd12});
    errors = errors + u_dut.u_assert.fail_cnt;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("watchdog expired, tests did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/sent_pkg.sv
hdl/sent_host_if.sv
hdl/sent_frame_fifo.sv
hdl/sent_tick_gen.sv
hdl/sent_frame_engine.sv
hdl/sent_tx.sv
tests/sent_tx_assertions.sv
tests/sent_tx_tb.sv

//--- Bender.yml
package:
  name: sent_tx

export_include_dirs:
  - include

sources:
  - hdl/sent_pkg.sv
  - hdl/sent_host_if.sv
  - hdl/sent_frame_fifo.sv
  - hdl/sent_tick_gen.sv
  - hdl/sent_frame_engine.sv
  - hdl/sent_tx.sv
  - target: test
    files:
      - tests/sent_tx_assertions.sv
      - tests/sent_tx_tb.sv
